// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  - src/fetch_pkg.sv
  - src/fetch_pc_gen.sv
  - src/fetch_ibus_port.sv
  - src/fetch_slot_buffer.sv
  - src/fetch_unit.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/tb_ibus_mem.sv
      - bench/fetch_unit_chk.sv
      - bench/tb_top.sv

// ==== bench/fetch_unit_chk.sv ====
module fetch_unit_chk (
    input logic                    clk,
    input logic                    reset,
    input logic                    redirect_valid,
    input logic                    exc_valid,
    input logic                    eret_valid,
    input logic                    stall,
    input logic                    ibus_valid,
    input fetch_pkg::addr_t        ibus_addr,
    input logic                    ibus_addr_ok,
    input fetch_pkg::addr_t        f1_pc,
    input logic                    out_valid,
    input fetch_pkg::addr_t        out_pc,
    input fetch_pkg::instr_t       out_instr0,
    input fetch_pkg::instr_t       out_instr1,
    input logic                    out_slot1_valid,
    input logic                    out_bad_addr
);
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    // read by the testbench top at the end
    int fail_count = 0;

    // bus and decode side both quiet right after reset
    reset_quiet: assert property (@(posedge clk) reset |=> !ibus_valid && !out_valid)
    else begin
        $error("ibus_valid or out_valid high right after reset");
        fail_count++;
    end

    // request held until addr_ok
    addr_hold: assert property (@(posedge clk) disable iff (reset)
        ibus_valid && !ibus_addr_ok |=> ibus_valid && $stable(ibus_addr))
    else begin
        $error("ibus request dropped or moved before addr_ok");
        fail_count++;
    end

    // misaligned pc goes out as a fault marker, never as a bus request
    no_misaligned_req: assert property (@(posedge clk) disable iff (reset)
        ibus_valid |-> f1_pc[1:0] == 2'b00)
    else begin
        $error("ibus request issued for a misaligned pc");
        fail_count++;
    end

    // packet frozen under stall, unless a redirect flushes it
    pkt_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && stall && !(redirect_valid || exc_valid || eret_valid)
        |=> out_valid && $stable(out_pc) && $stable(out_instr0) && $stable(out_instr1)
            && $stable(out_slot1_valid) && $stable(out_bad_addr))
    else begin
        $error("decode packet changed while stalled");
        fail_count++;
    end

    // fault marker carries no instructions
    bad_pkt_empty: assert property (@(posedge clk) disable iff (reset)
        out_valid && out_bad_addr
        |-> out_instr0 == '0 && out_instr1 == '0 && !out_slot1_valid)
    else begin
        $error("bad-address packet carries instruction data");
        fail_count++;
    end

    // slot 1 only when the pc sits in the lower half of the beat
    slot1_rule: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_bad_addr |-> out_slot1_valid == !out_pc[2])
    else begin
        $error("out_slot1_valid does not follow pc bit 2");
        fail_count++;
    end

endmodule

bind fetch_unit fetch_unit_chk chk0 (.*);

// ==== bench/tb_clock.sv ====
module tb_clock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // reset held for 10 cycles, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== bench/tb_ibus_mem.sv ====
module tb_ibus_mem (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    ibus_valid,
    input  fetch_pkg::addr_t        ibus_addr,
    output logic                    ibus_addr_ok,
    output logic                    ibus_data_ok,
    output fetch_pkg::fetch_block_t ibus_data
);
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    // accepted requests still owed a data beat, oldest first
    addr_t pend_addr  [$];
    int    pend_ready [$];

    // falling edges seen since reset
    int    cyc;
    // cycles still to wait before addr_ok
    int    addr_wait;
    addr_t head_addr;

    initial begin
        ibus_addr_ok = 1'b0;
        ibus_data_ok = 1'b0;
        ibus_data    = '0;
        cyc          = 0;
        addr_wait    = 0;
    end

    // everything toward the DUT changes on the falling edge
    always @(negedge clk) begin
        if (reset) begin
            ibus_addr_ok = 1'b0;
            ibus_data_ok = 1'b0;
            ibus_data    = '0;
            cyc          = 0;
            // first request answered at once
            addr_wait    = 0;
            pend_addr.delete();
            pend_ready.delete();
        end else begin
            cyc++;
            // data side, in order, 1 to 4 cycles after the handshake
            ibus_data_ok = 1'b0;
            if (pend_addr.size() > 0 && cyc >= pend_ready[0]) begin
                head_addr    = pend_addr.pop_front();
                void'(pend_ready.pop_front());
                ibus_data_ok = 1'b1;
                // word at A reads as A xor a5a5a5a5, lower word at lower address
                ibus_data    = {(head_addr + 32'd4) ^ 32'ha5a5a5a5,
                                head_addr ^ 32'ha5a5a5a5};
            end
            // address side, ibus_valid only moves on the rising edge
            ibus_addr_ok = 1'b0;
            if (ibus_valid) begin
                if (addr_wait == 0) begin
                    // handshake completes at the coming rising edge
                    ibus_addr_ok = 1'b1;
                    pend_addr.push_back(ibus_addr);
                    pend_ready.push_back(cyc + $urandom_range(1, 4));
                    addr_wait    = $urandom_range(0, 3);
                end else begin
                    addr_wait--;
                end
            end
        end
    end

endmodule

// ==== bench/tb_top.sv ====
module tb_top;
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    // packets per phase: quiet, stall only, stall plus redirects
    localparam int QUIET_PKTS    = 20;
    localparam int STALL_PKTS    = 60;
    localparam int REDIRECT_PKTS = 200;
    localparam int TOTAL_PKTS    = QUIET_PKTS + STALL_PKTS + REDIRECT_PKTS;
    // 40 cycles per packet, plus the reset time
    localparam int WATCHDOG_CYCLES = TOTAL_PKTS * 40 + 10;

    logic         clk;
    logic         reset;
    logic         redirect_valid;
    addr_t        redirect_pc;
    logic         exc_valid;
    logic         eret_valid;
    addr_t        epc;
    logic         stall;
    logic         ibus_valid;
    addr_t        ibus_addr;
    logic         ibus_addr_ok;
    logic         ibus_data_ok;
    fetch_block_t ibus_data;
    logic         out_valid;
    addr_t        out_pc;
    instr_t       out_instr0;
    instr_t       out_instr1;
    logic         out_slot1_valid;
    logic         out_bad_addr;

    // reference state
    addr_t exp_pc;
    bit    redir_wait;
    int    pkt_count;
    int    errors;
    bit    timed_out;

    tb_clock clock0 (
        .clk   (clk),
        .reset (reset)
    );

    tb_ibus_mem mem0 (
        .clk          (clk),
        .reset        (reset),
        .ibus_valid   (ibus_valid),
        .ibus_addr    (ibus_addr),
        .ibus_addr_ok (ibus_addr_ok),
        .ibus_data_ok (ibus_data_ok),
        .ibus_data    (ibus_data)
    );

    fetch_unit dut0 (
        .clk             (clk),
        .reset           (reset),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .exc_valid       (exc_valid),
        .eret_valid      (eret_valid),
        .epc             (epc),
        .ibus_addr_ok    (ibus_addr_ok),
        .ibus_data_ok    (ibus_data_ok),
        .ibus_data       (ibus_data),
        .stall           (stall),
        .ibus_valid      (ibus_valid),
        .ibus_addr       (ibus_addr),
        .out_valid       (out_valid),
        .out_pc          (out_pc),
        .out_instr0      (out_instr0),
        .out_instr1      (out_instr1),
        .out_slot1_valid (out_slot1_valid),
        .out_bad_addr    (out_bad_addr)
    );

    // memory contents rule
    function automatic instr_t mem_word(input addr_t a);
        return a ^ 32'ha5a5a5a5;
    endfunction

    // aligned, bit 2 set, or misaligned
    function automatic addr_t random_target();
        addr_t t;
        t = addr_t'($urandom) & ~addr_t'(3);
        case ($urandom_range(0, 2))
            0: t[2] = 1'b0;
            1: t[2] = 1'b1;
            default: t[1:0] = 2'($urandom_range(1, 3));
        endcase
        return t;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // one packet taken by decode against the reference pc
    task automatic check_packet();
        logic bad;
        bad = exp_pc[1:0] != 2'b00;
        check_value("out_pc", exp_pc, out_pc);
        check_value("out_bad_addr", 32'(bad), 32'(out_bad_addr));
        if (bad) begin
            check_value("out_instr0", '0, out_instr0);
            check_value("out_instr1", '0, out_instr1);
            check_value("out_slot1_valid", '0, 32'(out_slot1_valid));
        end else begin
            check_value("out_instr0", mem_word(exp_pc), out_instr0);
            check_value("out_slot1_valid", 32'(!exp_pc[2]), 32'(out_slot1_valid));
            if (!exp_pc[2]) begin
                check_value("out_instr1", mem_word(exp_pc + 32'd4), out_instr1);
            end
        end
    endtask

    // stall and redirect pulses for one cycle
    task automatic drive_inputs(input int stall_pct, input bit use_redirects);
        int mask;
        redirect_valid = 1'b0;
        exc_valid      = 1'b0;
        eret_valid     = 1'b0;
        stall          = $urandom_range(0, 99) < stall_pct;
        // next redirect only after the previous target came out
        if (use_redirects && !redir_wait && $urandom_range(0, 5) == 0) begin
            mask           = $urandom_range(1, 7);
            redirect_valid = mask[0];
            redirect_pc    = random_target();
            eret_valid     = mask[1];
            epc            = random_target();
            exc_valid      = mask[2];
        end
    endtask

    task automatic run_phase(input int packets, input int stall_pct, input bit use_redirects);
        int goal;
        goal = pkt_count + packets;
        while (pkt_count < goal) begin
            @(negedge clk);
            drive_inputs(stall_pct, use_redirects);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d data, %0d assertion", errors, dut0.chk0.fail_count);
        if (!timed_out && errors == 0 && dut0.chk0.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    // reference model, packet first, then any redirect seen this edge
    always @(posedge clk) begin
        if (reset) begin
            exp_pc     = RESET_VECTOR;
            redir_wait = 1'b0;
        end else begin
            if (out_valid && !stall) begin
                check_packet();
                // start of the following 8-byte beat
                exp_pc     = {exp_pc[ADDR_W-1:3] + 29'd1, 3'b000};
                redir_wait = 1'b0;
                pkt_count++;
            end
            // exception over eret over branch
            if (exc_valid) begin
                exp_pc = EXC_ENTRANCE;
            end else if (eret_valid) begin
                exp_pc = epc;
            end else if (redirect_valid) begin
                exp_pc = redirect_pc;
            end
            if (exc_valid || eret_valid || redirect_valid) begin
                redir_wait = 1'b1;
            end
        end
    end

    initial begin
        void'($urandom(55325));
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        exc_valid      = 1'b0;
        eret_valid     = 1'b0;
        epc            = '0;
        stall          = 1'b0;
        pkt_count      = 0;
        errors         = 0;
        timed_out      = 1'b0;
        @(negedge reset);
        run_phase(QUIET_PKTS, 0, 1'b0);
        run_phase(STALL_PKTS, 40, 1'b0);
        run_phase(REDIRECT_PKTS, 30, 1'b1);
        @(negedge clk);
        drive_inputs(0, 1'b0);
        repeat (5) @(negedge clk);
        finish_run();
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: only %0d of %0d packets reached decode", pkt_count, TOTAL_PKTS);
        timed_out = 1'b1;
        finish_run();
    end

endmodule

// ==== sources.f ====
src/fetch_pkg.sv
src/fetch_pc_gen.sv
src/fetch_ibus_port.sv
src/fetch_slot_buffer.sv
src/fetch_unit.sv
bench/tb_clock.sv
bench/tb_ibus_mem.sv
bench/fetch_unit_chk.sv
bench/tb_top.sv

// ==== src/fetch_ibus_port.sv ====
module fetch_ibus_port (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  fetch_pkg::addr_t        f1_pc,
    input  logic                    f1_valid,
    input  logic                    ibus_addr_ok,
    input  logic                    ibus_data_ok,
    input  fetch_pkg::fetch_block_t ibus_data,
    input  logic                    f2_stall,
    output logic                    f1_accept,
    output logic                    ibus_valid,
    output fetch_pkg::addr_t        ibus_addr,
    output logic                    f2_valid,
    output fetch_pkg::addr_t        f2_pc,
    output fetch_pkg::fetch_block_t f2_block,
    output logic                    f2_bad_addr
);
    import fetch_pkg::*;

    // in-order queue, entry 0 is the oldest
    logic         q_valid    [MAX_INFLIGHT];
    logic         q_has_data [MAX_INFLIGHT];
    logic         q_dropped  [MAX_INFLIGHT];
    logic         q_bad      [MAX_INFLIGHT];
    addr_t        q_pc       [MAX_INFLIGHT];
    fetch_block_t q_block    [MAX_INFLIGHT];

    // next queue contents
    logic         n_valid    [MAX_INFLIGHT];
    logic         n_has_data [MAX_INFLIGHT];
    logic         n_dropped  [MAX_INFLIGHT];
    logic         n_bad      [MAX_INFLIGHT];
    addr_t        n_pc       [MAX_INFLIGHT];
    fetch_block_t n_block    [MAX_INFLIGHT];

    // which entry the returning beat belongs to
    logic data_sel [MAX_INFLIGHT];
    logic waiting_seen;

    logic misaligned;
    logic room;
    logic head_ready;
    logic pop;
    logic push_done;

    // F1 pc changed at the last edge, flush arriving now then misses it
    logic accept_q;
    logic stale_pend;
    logic push_stale;

    // low two bits set means no bus request
    assign misaligned = f1_pc[1:0] != 2'b00;
    // held beats stay in the queue, so a full queue also blocks under stall
    assign room       = !q_valid[MAX_INFLIGHT-1];

    assign ibus_valid = f1_valid && room && !misaligned;
    assign ibus_addr  = f1_pc & ~addr_t'(BLOCK_BYTES - 1);
    assign f1_accept  = f1_valid && room && (misaligned || ibus_addr_ok);

    // pc still in F1 when the flush came belongs to the old stream
    assign push_stale = stale_pend || (flush && !accept_q);

    // beats come back in order, the oldest entry still waiting takes it
    always_comb begin
        waiting_seen = 1'b0;
        for (int i = 0; i < MAX_INFLIGHT; i++) begin
            data_sel[i] = ibus_data_ok && q_valid[i] && !q_has_data[i] && !waiting_seen;
            if (q_valid[i] && !q_has_data[i]) begin
                waiting_seen = 1'b1;
            end
        end
    end

    // beat bypasses the queue when it arrives for the head
    assign head_ready  = q_valid[0] && (q_has_data[0] || data_sel[0]);
    assign f2_valid    = head_ready && !q_dropped[0];
    assign f2_pc       = q_pc[0];
    assign f2_block    = q_has_data[0] ? q_block[0] : ibus_data;
    assign f2_bad_addr = q_bad[0];
    // dropped beats leave at once, live ones once F2 takes them
    assign pop         = head_ready && (q_dropped[0] || !f2_stall);

    always_comb begin
        for (int i = 0; i < MAX_INFLIGHT; i++) begin
            n_valid[i]    = q_valid[i];
            n_has_data[i] = q_has_data[i] || data_sel[i];
            n_dropped[i]  = q_dropped[i] || flush;
            n_bad[i]      = q_bad[i];
            n_pc[i]       = q_pc[i];
            n_block[i]    = data_sel[i] ? ibus_data : q_block[i];
        end
        // shift out the head
        if (pop) begin
            for (int i = 0; i < MAX_INFLIGHT - 1; i++) begin
                n_valid[i]    = n_valid[i+1];
                n_has_data[i] = n_has_data[i+1];
                n_dropped[i]  = n_dropped[i+1];
                n_bad[i]      = n_bad[i+1];
                n_pc[i]       = n_pc[i+1];
                n_block[i]    = n_block[i+1];
            end
            n_valid[MAX_INFLIGHT-1] = 1'b0;
        end
        // new pc goes to the first free slot
        push_done = 1'b0;
        if (f1_accept) begin
            for (int i = 0; i < MAX_INFLIGHT; i++) begin
                if (!push_done && !n_valid[i]) begin
                    n_valid[i]    = 1'b1;
                    // bad address needs no beat
                    n_has_data[i] = misaligned;
                    n_dropped[i]  = push_stale;
                    n_bad[i]      = misaligned;
                    n_pc[i]       = f1_pc;
                    n_block[i]    = '0;
                    push_done     = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            accept_q   <= 1'b0;
            stale_pend <= 1'b0;
            for (int i = 0; i < MAX_INFLIGHT; i++) begin
                q_valid[i]    <= 1'b0;
                q_has_data[i] <= 1'b0;
                q_dropped[i]  <= 1'b0;
            end
        end else begin
            accept_q <= f1_accept;
            if (f1_accept) begin
                stale_pend <= 1'b0;
            end else if (flush && !accept_q) begin
                stale_pend <= 1'b1;
            end
            for (int i = 0; i < MAX_INFLIGHT; i++) begin
                q_valid[i]    <= n_valid[i];
                q_has_data[i] <= n_has_data[i];
                q_dropped[i]  <= n_dropped[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < MAX_INFLIGHT; i++) begin
            q_bad[i]   <= n_bad[i];
            q_pc[i]    <= n_pc[i];
            q_block[i] <= n_block[i];
        end
    end

endmodule

// ==== src/fetch_pc_gen.sv ====
module fetch_pc_gen (
    input  logic             clk,
    input  logic             reset,
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             exc_valid,
    input  logic             eret_valid,
    input  fetch_pkg::addr_t epc,
    input  logic             f1_accept,
    output fetch_pkg::addr_t f1_pc,
    output logic             f1_valid,
    output logic             flush
);
    import fetch_pkg::*;

    pc_state_t state;

    // target kept while F1 is stalled
    addr_t saved_pc;

    // sequential successor of the current pc
    addr_t seq_pc;

    // redirect arriving this cycle
    logic  hi_pri_req;
    logic  any_req;
    logic  take_new;
    addr_t new_target;

    // target to load once F1 accepts
    logic  pending;
    addr_t pend_target;

    // exception beats eret, eret beats branch
    assign hi_pri_req = exc_valid || eret_valid;
    assign any_req    = hi_pri_req || redirect_valid;

    always_comb begin
        if (exc_valid) begin
            new_target = EXC_ENTRANCE;
        end else if (eret_valid) begin
            new_target = epc;
        end else begin
            new_target = redirect_pc;
        end
    end

    // a saved exc/eret target is not replaced by a later branch
    assign take_new = hi_pri_req || (redirect_valid && state != HOLD_EXC);

    assign pending     = take_new || state != RUN;
    assign pend_target = take_new ? new_target : saved_pc;

    // align down to the beat, then step one beat
    assign seq_pc = (f1_pc & ~addr_t'(BLOCK_BYTES - 1)) + addr_t'(BLOCK_BYTES);

    always_ff @(posedge clk) begin
        if (reset) begin
            f1_pc    <= RESET_VECTOR;
            f1_valid <= 1'b0;
            state    <= RUN;
            flush    <= 1'b0;
        end else begin
            // F1 holds a pc every cycle once out of reset
            f1_valid <= 1'b1;
            // later stages drop their contents one cycle after any redirect
            flush    <= any_req;
            if (f1_accept) begin
                // pc leaves F1, so the next one can be loaded
                f1_pc <= pending ? pend_target : seq_pc;
                state <= RUN;
            end else if (take_new) begin
                // F1 busy, keep the target for later
                state <= hi_pri_req ? HOLD_EXC : HOLD_REDIRECT;
            end
        end
    end

    // payload only, its meaning is given by state
    always_ff @(posedge clk) begin
        if (!f1_accept && take_new) begin
            saved_pc <= new_target;
        end
    end

endmodule

// ==== src/fetch_pkg.sv ====
package fetch_pkg;

    // address width of the fetch path
    localparam int ADDR_W = 32;

    // one instruction word
    localparam int INSTR_W = 32;

    // byte address
    typedef logic [ADDR_W-1:0] addr_t;

    // single instruction word
    typedef logic [INSTR_W-1:0] instr_t;

    // one 64-bit bus beat, lower word sits at the lower address
    typedef logic [2*INSTR_W-1:0] fetch_block_t;

    // first fetch after reset
    localparam addr_t RESET_VECTOR = 32'hbfc0_0000;

    // general exception entry point
    localparam addr_t EXC_ENTRANCE = 32'hbfc0_0380;

    // bytes covered by one bus beat
    localparam int BLOCK_BYTES = 8;

    // bus fetches allowed outstanding at once
    // held beats count against this too
    localparam int MAX_INFLIGHT = 2;

    // pc generator states
    // RUN            normal sequential fetch
    // HOLD_REDIRECT  branch target waiting for F1 to accept
    // HOLD_EXC       exception or eret target waiting, a branch cannot replace it
    typedef enum logic [1:0] {
        RUN,
        HOLD_REDIRECT,
        HOLD_EXC
    } pc_state_t;

endpackage

// ==== src/fetch_slot_buffer.sv ====
module fetch_slot_buffer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    f2_valid,
    input  fetch_pkg::addr_t        f2_pc,
    input  fetch_pkg::fetch_block_t f2_block,
    input  logic                    f2_bad_addr,
    input  logic                    stall,
    output logic                    f2_stall,
    output logic                    out_valid,
    output fetch_pkg::addr_t        out_pc,
    output fetch_pkg::instr_t       out_instr0,
    output fetch_pkg::instr_t       out_instr1,
    output logic                    out_slot1_valid,
    output logic                    out_bad_addr
);
    import fetch_pkg::*;

    // the two words of the incoming beat
    instr_t lo_word;
    instr_t hi_word;

    // packet formed from the beat
    instr_t sel_instr0;
    instr_t sel_instr1;
    logic   sel_slot1_valid;

    // packet register occupied
    logic   pkt_valid;

    // beat taken into the packet register
    logic   load;

    // lower word at the lower address
    assign lo_word = f2_block[INSTR_W-1:0];
    assign hi_word = f2_block[2*INSTR_W-1:INSTR_W];

    always_comb begin
        if (f2_bad_addr) begin
            // fault marker carries no instructions
            sel_instr0      = '0;
            sel_instr1      = '0;
            sel_slot1_valid = 1'b0;
        end else if (f2_pc[2]) begin
            // pc in the upper half of the beat
            // only one word left in this beat
            sel_instr0      = hi_word;
            sel_instr1      = '0;
            sel_slot1_valid = 1'b0;
        end else begin
            // aligned pc, both words go to decode
            sel_instr0      = lo_word;
            sel_instr1      = hi_word;
            sel_slot1_valid = 1'b1;
        end
    end

    // old packet is hidden during the flush cycle
    assign out_valid = pkt_valid && !flush;

    // decode holds a valid packet, so F2 must wait
    assign f2_stall  = out_valid && stall;

    // new beat only when the register is free or drained this cycle
    assign load      = f2_valid && !f2_stall && !flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            pkt_valid <= 1'b0;
        end else if (flush) begin
            pkt_valid <= 1'b0;
        end else if (!f2_stall) begin
            // empty or consumed, refill from F2 or go empty
            pkt_valid <= f2_valid;
        end
    end

    // packet payload, qualified by pkt_valid
    always_ff @(posedge clk) begin
        if (load) begin
            out_pc          <= f2_pc;
            out_instr0      <= sel_instr0;
            out_instr1      <= sel_instr1;
            out_slot1_valid <= sel_slot1_valid;
            out_bad_addr    <= f2_bad_addr;
        end
    end

endmodule

// ==== src/fetch_unit.sv ====
module fetch_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    redirect_valid,
    input  fetch_pkg::addr_t        redirect_pc,
    input  logic                    exc_valid,
    input  logic                    eret_valid,
    input  fetch_pkg::addr_t        epc,
    input  logic                    ibus_addr_ok,
    input  logic                    ibus_data_ok,
    input  fetch_pkg::fetch_block_t ibus_data,
    input  logic                    stall,
    output logic                    ibus_valid,
    output fetch_pkg::addr_t        ibus_addr,
    output logic                    out_valid,
    output fetch_pkg::addr_t        out_pc,
    output fetch_pkg::instr_t       out_instr0,
    output fetch_pkg::instr_t       out_instr1,
    output logic                    out_slot1_valid,
    output logic                    out_bad_addr
);
    import fetch_pkg::*;

    // pc generator to F1
    addr_t        f1_pc;
    logic         f1_valid;
    logic         f1_accept;
    // registered redirect, clears all stages
    logic         flush;

    // F2 beat toward the slot buffer
    logic         f2_valid;
    addr_t        f2_pc;
    fetch_block_t f2_block;
    logic         f2_bad_addr;
    logic         f2_stall;

    // pc register and redirect priority
    fetch_pc_gen pc_gen0 (
        .clk            (clk),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .exc_valid      (exc_valid),
        .eret_valid     (eret_valid),
        .epc            (epc),
        .f1_accept      (f1_accept),
        .f1_pc          (f1_pc),
        .f1_valid       (f1_valid),
        .flush          (flush)
    );

    // F1 request and F2 return
    fetch_ibus_port ibus_port0 (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .f1_pc        (f1_pc),
        .f1_valid     (f1_valid),
        .ibus_addr_ok (ibus_addr_ok),
        .ibus_data_ok (ibus_data_ok),
        .ibus_data    (ibus_data),
        .f2_stall     (f2_stall),
        .f1_accept    (f1_accept),
        .ibus_valid   (ibus_valid),
        .ibus_addr    (ibus_addr),
        .f2_valid     (f2_valid),
        .f2_pc        (f2_pc),
        .f2_block     (f2_block),
        .f2_bad_addr  (f2_bad_addr)
    );

    // F2 to decode packet register
    fetch_slot_buffer slot_buffer0 (
        .clk             (clk),
        .reset           (reset),
        .flush           (flush),
        .f2_valid        (f2_valid),
        .f2_pc           (f2_pc),
        .f2_block        (f2_block),
        .f2_bad_addr     (f2_bad_addr),
        .stall           (stall),
        .f2_stall        (f2_stall),
        .out_valid       (out_valid),
        .out_pc          (out_pc),
        .out_instr0      (out_instr0),
        .out_instr1      (out_instr1),
        .out_slot1_valid (out_slot1_valid),
        .out_bad_addr    (out_bad_addr)
    );

endmodule
